// File: Makefile
# Verilator build of the decode stage testbench, with run and clean targets

SOURCES := all.f $(wildcard include/*.svh logic/*.sv dv/*.sv)

obj_dir/Vdecode_tb: $(SOURCES)
	verilator --binary --top-module decode_tb -f all.f

run: obj_dir/Vdecode_tb
	obj_dir/Vdecode_tb | tee sim.log
	grep -q '^Simulation passed$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: all.f
+incdir+include
logic/decode_pkg.sv
logic/op_decoder.sv
logic/operand_builder.sv
logic/decode_issue.sv
logic/decode_top.sv
dv/decode_tb.sv

// File: dv/decode_tb.sv
// Self-checking testbench for decode_top; directed stall and kill cases, then random RV32IM traffic
`include "decode_macros.svh"

module decode_tb
    import decode_pkg::*;
();

    localparam int SEED       = 39;
    localparam int NUM_RANDOM = 600;
    // Directed part and held instructions stay well below the margin
    localparam int MAX_CYCLES = 3 * NUM_RANDOM + 200;

    localparam logic [6:0] OPCODES [11] = '{`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
        `OPC_BRANCH, `OPC_LOAD, `OPC_STORE, `OPC_OP_IMM, `OPC_OP, `OPC_MISC_MEM, `OPC_SYSTEM};
    localparam logic [6:0] OP_FUNCT7 [3] = '{7'h00, 7'h01, 7'h20};
    localparam word_t PRIV_WORDS [4] = '{32'h00000073, 32'h00100073, 32'h30200073, 32'h10500073};

    // Operation by funct3
    localparam op_e BRANCH_OPS [8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    localparam op_e LOAD_OPS [8]   = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    localparam op_e STORE_OPS [8]  = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    localparam op_e ALU_OPS [8]    = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    localparam op_e MULDIV_OPS [8] = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    localparam op_e CSR_OPS [8]    = '{INVALID, CSRRW, CSRRS, CSRRC, INVALID, CSRRWI, CSRRSI, CSRRCI};

    typedef struct packed {
        op_e        op;
        word_t      pc;
        word_t      opnd1;
        word_t      opnd2;
        word_t      opnd3;
        reg_idx_t   rd;
        logic       killed;
        logic       illegal;
        logic       misaligned;
        logic       access_fault;
    } outputs_t;

    logic       clk = 1'b0;
    logic       reset_n = 1'b0;
    logic       enable_i;
    word_t      instruction_i;
    word_t      pc_i;
    word_t      rs1_data_i;
    word_t      rs2_data_i;
    word_t      result_i;
    word_t      writeback_i;
    reg_idx_t   rd_retire_i;
    logic       execute_we_i;
    logic       regbank_we_i;
    logic       jumping_i;
    logic       rollback_i;
    logic       access_fault_i;

    reg_idx_t   rs1_o;
    reg_idx_t   rs2_o;
    op_e        operation_o;
    word_t      pc_o;
    word_t      first_operand_o;
    word_t      second_operand_o;
    word_t      third_operand_o;
    reg_idx_t   rd_o;
    logic       hazard_o;
    logic       killed_o;
    logic       exc_illegal_o;
    logic       exc_misaligned_o;
    logic       exc_access_fault_o;

    // Reference model state
    outputs_t   expected;
    reg_idx_t   lock_rd;
    logic       lock_st;
    logic       exp_hazard;
    logic       bubble;
    logic       hold_fetch = 1'b0;

    int         error_count = 0;
    int         check_count = 0;
    int         stall_count = 0;
    int         cycle_count = 0;
    word_t      pc_q;
    logic [32:0] directed [$];
    logic [32:0] entry;

    decode_top dut (.*);

    initial begin
        forever begin
            #10 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic op_e ref_op(input word_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        case (ins[6:0])
            `OPC_LUI:      return LUI;
            `OPC_AUIPC:    return ADD;
            `OPC_JAL:      return JAL;
            `OPC_JALR:     return (f3 == 3'd0) ? JALR : INVALID;
            `OPC_BRANCH:   return BRANCH_OPS[f3];
            `OPC_LOAD:     return LOAD_OPS[f3];
            `OPC_STORE:    return STORE_OPS[f3];
            // Shift amounts carry a funct7 that must be legal
            `OPC_OP_IMM:   return (f3 != 3'd1 && f3 != 3'd5) ? ALU_OPS[f3] :
                                  (f7 == 7'h00) ? ALU_OPS[f3] :
                                  (f7 == 7'h20 && f3 == 3'd5) ? SRA : INVALID;
            `OPC_OP:       return (f7 == 7'h00) ? ALU_OPS[f3] :
                                  (f7 == 7'h01) ? MULDIV_OPS[f3] :
                                  (f7 == 7'h20 && f3 == 3'd0) ? SUB :
                                  (f7 == 7'h20 && f3 == 3'd5) ? SRA : INVALID;
            `OPC_MISC_MEM: return (f3 == 3'd0) ? NOP : INVALID;
            `OPC_SYSTEM:   return (f3 != 3'd0) ? CSR_OPS[f3] :
                                  (ins == 32'h00000073) ? ECALL :
                                  (ins == 32'h00100073) ? EBREAK :
                                  (ins == 32'h30200073) ? MRET :
                                  (ins == 32'h10500073) ? WFI : INVALID;
            default:       return INVALID;
        endcase
    endfunction

    function automatic format_e ref_format(input logic [6:0] opc);
        case (opc)
            `OPC_LUI, `OPC_AUIPC:              return U_TYPE;
            `OPC_JAL:                          return J_TYPE;
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: return I_TYPE;
            `OPC_STORE:                        return S_TYPE;
            `OPC_BRANCH:                       return B_TYPE;
            default:                           return R_TYPE;
        endcase
    endfunction

    function automatic word_t ref_imm(input word_t ins, input format_e fmt);
        case (fmt)
            I_TYPE:  return {{20{ins[31]}}, ins[31:20]};
            S_TYPE:  return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            B_TYPE:  return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            U_TYPE:  return {ins[31:12], 12'h000};
            J_TYPE:  return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    function automatic logic is_load(input op_e op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    // Execute stage first, then retire, then bank
    function automatic word_t forward(input reg_idx_t idx, input word_t bank);
        if (idx == expected.rd && execute_we_i) begin
            return result_i;
        end
        if (idx == rd_retire_i && regbank_we_i) begin
            return writeback_i;
        end
        return bank;
    endfunction

    function automatic logic ref_hazard();
        format_e fmt;
        logic    use1;
        logic    use2;
        fmt  = ref_format(instruction_i[6:0]);
        use1 = (fmt != U_TYPE) && (fmt != J_TYPE);
        use2 = (fmt == R_TYPE) || (fmt == B_TYPE) || (fmt == S_TYPE);
        if (jumping_i || rollback_i) begin
            return 1'b0;
        end
        return (lock_rd != '0 && ((lock_rd == instruction_i[19:15] && use1) ||
                                  (lock_rd == instruction_i[24:20] && use2))) ||
               (lock_st && is_load(ref_op(instruction_i)));
    endfunction

    // Outputs after the next enabled edge
    function automatic outputs_t predict(input logic make_bubble);
        outputs_t o;
        format_e  fmt;
        word_t    imm;
        o = '0;
        o.killed = jumping_i || rollback_i;
        if (make_bubble) begin
            return o;
        end
        fmt = ref_format(instruction_i[6:0]);
        imm = ref_imm(instruction_i, fmt);
        o.op    = ref_op(instruction_i);
        o.pc    = pc_i;
        o.rd    = instruction_i[11:7];
        o.opnd1 = (fmt == U_TYPE || fmt == J_TYPE) ? pc_i :
                  forward(instruction_i[19:15], rs1_data_i);
        o.opnd2 = (fmt == R_TYPE || fmt == B_TYPE) ?
                  forward(instruction_i[24:20], rs2_data_i) : imm;
        o.opnd3 = (fmt == S_TYPE) ? forward(instruction_i[24:20], rs2_data_i) : imm;
        o.illegal      = (o.op == INVALID);
        o.misaligned   = (pc_i[1:0] != 2'b00);
        o.access_fault = access_fault_i;
        return o;
    endfunction

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
        end
    endtask

    task automatic compare_outputs();
        check("rs1_o", 32'(instruction_i[19:15]), 32'(rs1_o));
        check("rs2_o", 32'(instruction_i[24:20]), 32'(rs2_o));
        check("operation_o", 32'(expected.op), 32'(operation_o));
        check("pc_o", expected.pc, pc_o);
        check("first_operand_o", expected.opnd1, first_operand_o);
        check("second_operand_o", expected.opnd2, second_operand_o);
        check("third_operand_o", expected.opnd3, third_operand_o);
        check("rd_o", 32'(expected.rd), 32'(rd_o));
        check("killed_o", 32'(expected.killed), 32'(killed_o));
        check("exc_illegal_o", 32'(expected.illegal), 32'(exc_illegal_o));
        check("exc_misaligned_o", 32'(expected.misaligned), 32'(exc_misaligned_o));
        check("exc_access_fault_o", 32'(expected.access_fault), 32'(exc_access_fault_o));
    endtask

    // Outputs and hazard are stable at the falling edge
    always @(negedge clk) begin
        if (!reset_n) begin
            expected = '0;
            lock_rd  = '0;
            lock_st  = 1'b0;
        end
        compare_outputs();
        exp_hazard = ref_hazard();
        check("hazard_o", 32'(exp_hazard), 32'(hazard_o));
        hold_fetch = hazard_o;
        if (reset_n && enable_i) begin
            if (hazard_o) begin
                stall_count++;
            end
            bubble   = exp_hazard || jumping_i || rollback_i;
            expected = predict(bubble);
            // A bubble predicts NOP, which clears the lock
            lock_rd  = is_load(expected.op) ? expected.rd : '0;
            lock_st  = expected.op inside {SB, SH, SW};
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: stimulus still running after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    function automatic word_t encode_rtype(input logic [6:0] f7, input reg_idx_t rs2,
                                           input reg_idx_t rs1, input logic [2:0] f3,
                                           input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encode_itype(input logic [11:0] imm, input reg_idx_t rs1,
                                           input logic [2:0] f3, input reg_idx_t rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Mostly legal words; registers kept to x0..x7 so that indexes collide often
    function automatic word_t rand_instr();
        word_t ins;
        ins = $urandom;
        if ($urandom_range(9) == 0) begin
            return ins;
        end
        ins[6:0]   = OPCODES[4'($urandom_range(10))];
        ins[11:7]  = 5'($urandom_range(7));
        ins[19:15] = 5'($urandom_range(7));
        ins[24:20] = 5'($urandom_range(7));
        case (ins[6:0])
            `OPC_OP: ins[31:25] = OP_FUNCT7[2'($urandom_range(2))];
            `OPC_OP_IMM: begin
                if (ins[13:12] == 2'b01) begin
                    ins[31:25] = ($urandom_range(1) == 0) ? 7'h00 : 7'h20;
                end
            end
            `OPC_SYSTEM: begin
                if (ins[14:12] == 3'd0) begin
                    ins = PRIV_WORDS[2'($urandom_range(3))];
                end
            end
            default: ;
        endcase
        return ins;
    endfunction

    task automatic randomize_data();
        rs1_data_i   <= $urandom;
        rs2_data_i   <= $urandom;
        result_i     <= $urandom;
        writeback_i  <= $urandom;
        rd_retire_i  <= 5'($urandom_range(7));
        execute_we_i <= 1'($urandom_range(1));
        regbank_we_i <= 1'($urandom_range(1));
    endtask

    // Occasional unaligned fetch address
    task automatic advance_pc();
        pc_q = pc_q + 32'd4;
        if ($urandom_range(15) == 0) begin
            pc_i <= pc_q | 32'($urandom_range(3, 1));
        end else begin
            pc_i <= pc_q;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        enable_i       = 1'b1;
        instruction_i  = 32'h00000013;
        pc_i           = '0;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        result_i       = '0;
        writeback_i    = '0;
        rd_retire_i    = '0;
        execute_we_i   = 1'b0;
        regbank_we_i   = 1'b0;
        jumping_i      = 1'b0;
        rollback_i     = 1'b0;
        access_fault_i = 1'b0;
        pc_q           = '0;

        // Bit 32 asserts jumping_i with that instruction
        // U and J words carry x5 in both source fields
        directed = '{
            {1'b0, encode_itype(12'h010, 5'd2, 3'b010, 5'd5, `OPC_LOAD)},
            {1'b0, encode_rtype(7'h00, 5'd1, 5'd5, 3'b000, 5'd6, `OPC_OP)},
            {1'b0, encode_itype(12'h004, 5'd2, 3'b010, 5'd0, `OPC_LOAD)},
            {1'b0, encode_rtype(7'h00, 5'd0, 5'd0, 3'b000, 5'd7, `OPC_OP)},
            {1'b0, encode_itype(12'h008, 5'd2, 3'b010, 5'd5, `OPC_LOAD)},
            {1'b0, 20'h12528, 5'd5, `OPC_LUI},
            {1'b0, encode_itype(12'h00c, 5'd2, 3'b010, 5'd5, `OPC_LOAD)},
            {1'b0, 20'h00528, 5'd5, `OPC_JAL},
            {1'b0, encode_rtype(7'h00, 5'd5, 5'd2, 3'b010, 5'd0, `OPC_STORE)},
            {1'b0, encode_itype(12'h000, 5'd2, 3'b010, 5'd7, `OPC_LOAD)},
            {1'b0, encode_itype(12'h010, 5'd2, 3'b010, 5'd5, `OPC_LOAD)},
            {1'b1, encode_rtype(7'h00, 5'd1, 5'd5, 3'b000, 5'd6, `OPC_OP)},
            {1'b0, encode_rtype(7'h00, 5'd1, 5'd5, 3'b000, 5'd6, `OPC_OP)}
        };

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        // Load-use, x0, U and J, store then load, and kill
        while (directed.size() != 0) begin
            @(posedge clk);
            randomize_data();
            jumping_i <= 1'b0;
            if (!hold_fetch) begin
                entry = directed.pop_front();
                instruction_i <= entry[31:0];
                jumping_i     <= entry[32];
                advance_pc();
            end
        end

        // Random traffic with fetch held during stalls
        repeat (NUM_RANDOM) begin
            @(posedge clk);
            randomize_data();
            enable_i       <= ($urandom_range(9) != 0);
            jumping_i      <= ($urandom_range(15) == 0);
            rollback_i     <= ($urandom_range(15) == 0);
            access_fault_i <= ($urandom_range(15) == 0);
            if (!hold_fetch) begin
                instruction_i <= rand_instr();
                advance_pc();
            end
        end

        repeat (3) @(posedge clk);
        if (stall_count == 0) begin
            $display("No stall was seen during the run");
            error_count++;
        end
        $display("Run done: %0d checks, %0d errors, %0d stalls",
                 check_count, error_count, stall_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: include/decode_macros.svh
// Widths and RV32 major opcode values, included by the decode stage sources and the testbench
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Datapath widths
`define XLEN            32
`define REG_ADDR_W      5

// Major opcodes in instr[6:0]
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_MISC_MEM    7'b0001111
`define OPC_SYSTEM      7'b1110011

`endif

// File: logic/decode_issue.sv
// Issue stage of decode; holds the load lock, raises hazard and kill, registers outputs or a bubble
module decode_issue
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        enable_i,
    input  logic        jumping_i,
    input  logic        rollback_i,
    input  logic        access_fault_i,
    input  logic        illegal_i,
    input  logic        use_rs1_i,
    input  logic        use_rs2_i,
    input  op_e         operation_i,
    input  word_t       pc_i,
    input  word_t       first_operand_i,
    input  word_t       second_operand_i,
    input  word_t       third_operand_i,
    input  reg_idx_t    rs1_i,
    input  reg_idx_t    rs2_i,
    input  reg_idx_t    rd_i,

    output op_e         operation_o,
    output word_t       pc_o,
    output word_t       first_operand_o,
    output word_t       second_operand_o,
    output word_t       third_operand_o,
    output reg_idx_t    rd_o,
    output logic        hazard_o,
    output logic        killed_o,
    output logic        exc_illegal_o,
    output logic        exc_misaligned_o,
    output logic        exc_access_fault_o
);

    logic       is_load;
    logic       is_store;
    logic       killed;
    logic       bubble;
    logic       misaligned;
    reg_idx_t   locked_reg;
    logic       locked_mem;

    assign is_load  = (operation_i inside {LB, LH, LW, LBU, LHU});
    assign is_store = (operation_i inside {SB, SH, SW});

    //////////////////////////////////////////////////
    // Kill and hazard
    //////////////////////////////////////////////////

    assign killed = jumping_i || rollback_i;

    // x0 never locks, so a zero lock means free
    assign hazard_o = !killed &&
                      ((locked_reg != '0 && locked_reg == rs1_i && use_rs1_i) ||
                       (locked_reg != '0 && locked_reg == rs2_i && use_rs2_i) ||
                       (locked_mem && is_load));

    assign bubble     = hazard_o || killed;
    assign misaligned = (pc_i[1:0] != 2'b00);

    //////////////////////////////////////////////////
    // Register lock
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
        end else if (enable_i) begin
            if (bubble) begin
                locked_reg <= '0;
                locked_mem <= 1'b0;
            end else begin
                locked_reg <= is_load ? rd_i : '0;
                locked_mem <= is_store;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            operation_o        <= NOP;
            pc_o               <= '0;
            first_operand_o    <= '0;
            second_operand_o   <= '0;
            third_operand_o    <= '0;
            rd_o               <= '0;
            killed_o           <= 1'b0;
            exc_illegal_o      <= 1'b0;
            exc_misaligned_o   <= 1'b0;
            exc_access_fault_o <= 1'b0;
        end else if (enable_i) begin
            killed_o <= killed;
            if (bubble) begin
                // Bubble issued as a clean NOP
                operation_o        <= NOP;
                pc_o               <= '0;
                first_operand_o    <= '0;
                second_operand_o   <= '0;
                third_operand_o    <= '0;
                rd_o               <= '0;
                exc_illegal_o      <= 1'b0;
                exc_misaligned_o   <= 1'b0;
                exc_access_fault_o <= 1'b0;
            end else begin
                operation_o        <= operation_i;
                pc_o               <= pc_i;
                first_operand_o    <= first_operand_i;
                second_operand_o   <= second_operand_i;
                third_operand_o    <= third_operand_i;
                rd_o               <= rd_i;
                exc_illegal_o      <= illegal_i;
                exc_misaligned_o   <= misaligned;
                exc_access_fault_o <= access_fault_i;
            end
        end
    end

endmodule

// File: logic/decode_pkg.sv
// Word, register index, operation and format types, imported by every decode stage module
`include "decode_macros.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // Decoded operation, NOP must stay at zero for bubbles
    typedef enum logic [5:0] {
        NOP,
        LUI,
        ADD, SUB,
        SLL, SLT, SLTU,
        XOR, SRL, SRA,
        OR, AND,
        // Control transfer
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        // Memory
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        // M extension
        MUL, MULH, MULHSU, MULHU,
        DIV, DIVU, REM, REMU,
        // System and CSR access
        ECALL, EBREAK, MRET, WFI,
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI,
        INVALID
    } op_e;

    // Instruction encoding format
    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

endpackage

// File: logic/decode_top.sv
// Decode stage top level; slices instruction fields and joins operation decode, operands and issue
module decode_top
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        enable_i,

    input  word_t       instruction_i,
    input  word_t       pc_i,
    input  word_t       rs1_data_i,
    input  word_t       rs2_data_i,
    input  word_t       result_i,
    input  word_t       writeback_i,
    input  reg_idx_t    rd_retire_i,
    input  logic        execute_we_i,
    input  logic        regbank_we_i,
    input  logic        jumping_i,
    input  logic        rollback_i,
    input  logic        access_fault_i,

    // Register bank read addresses
    output reg_idx_t    rs1_o,
    output reg_idx_t    rs2_o,

    output op_e         operation_o,
    output word_t       pc_o,
    output word_t       first_operand_o,
    output word_t       second_operand_o,
    output word_t       third_operand_o,
    output reg_idx_t    rd_o,
    output logic        hazard_o,
    output logic        killed_o,
    output logic        exc_illegal_o,
    output logic        exc_misaligned_o,
    output logic        exc_access_fault_o
);

    reg_idx_t   rd;
    op_e        operation;
    logic       illegal;
    word_t      first_operand;
    word_t      second_operand;
    word_t      third_operand;
    logic       use_rs1;
    logic       use_rs2;

    assign rs1_o = instruction_i[19:15];
    assign rs2_o = instruction_i[24:20];
    assign rd    = instruction_i[11:7];

    op_decoder u_op (
        .instr_i     (instruction_i),
        .operation_o (operation),
        .illegal_o   (illegal)
    );

    // rd_o is the destination now in execute
    operand_builder u_opnd (
        .instr_i          (instruction_i),
        .pc_i             (pc_i),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .result_i         (result_i),
        .writeback_i      (writeback_i),
        .rd_exec_i        (rd_o),
        .rd_retire_i      (rd_retire_i),
        .execute_we_i     (execute_we_i),
        .regbank_we_i     (regbank_we_i),
        .first_operand_o  (first_operand),
        .second_operand_o (second_operand),
        .third_operand_o  (third_operand),
        .use_rs1_o        (use_rs1),
        .use_rs2_o        (use_rs2)
    );

    decode_issue u_issue (
        .clk                (clk),
        .reset_n            (reset_n),
        .enable_i           (enable_i),
        .jumping_i          (jumping_i),
        .rollback_i         (rollback_i),
        .access_fault_i     (access_fault_i),
        .illegal_i          (illegal),
        .use_rs1_i          (use_rs1),
        .use_rs2_i          (use_rs2),
        .operation_i        (operation),
        .pc_i               (pc_i),
        .first_operand_i    (first_operand),
        .second_operand_i   (second_operand),
        .third_operand_i    (third_operand),
        .rs1_i              (rs1_o),
        .rs2_i              (rs2_o),
        .rd_i               (rd),
        .operation_o        (operation_o),
        .pc_o               (pc_o),
        .first_operand_o    (first_operand_o),
        .second_operand_o   (second_operand_o),
        .third_operand_o    (third_operand_o),
        .rd_o               (rd_o),
        .hazard_o           (hazard_o),
        .killed_o           (killed_o),
        .exc_illegal_o      (exc_illegal_o),
        .exc_misaligned_o   (exc_misaligned_o),
        .exc_access_fault_o (exc_access_fault_o)
    );

endmodule

// File: logic/op_decoder.sv
// Combinational RV32IM operation decoder; maps one instruction word to op_e and an illegal flag
`include "decode_macros.svh"

module op_decoder
    import decode_pkg::*;
(
    input  word_t   instr_i,
    output op_e     operation_o,
    output logic    illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    //////////////////////////////////////////////////
    // Per-opcode tables
    //////////////////////////////////////////////////

    op_e op_branch;
    op_e op_load;
    op_e op_store;
    op_e op_imm;
    op_e op_reg;
    op_e op_system;

    always_comb begin
        case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift immediates keep funct7 as part of the encoding
    always_comb begin
        case (funct3)
            3'b000:  op_imm = ADD;
            3'b001:  op_imm = (funct7 == 7'b0000000) ? SLL : INVALID;
            3'b010:  op_imm = SLT;
            3'b011:  op_imm = SLTU;
            3'b100:  op_imm = XOR;
            3'b101:  op_imm = (funct7 == 7'b0000000) ? SRL :
                              (funct7 == 7'b0100000) ? SRA : INVALID;
            3'b110:  op_imm = OR;
            default: op_imm = AND;
        endcase
    end

    // Base ALU ops and M extension share the OP opcode
    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: op_reg = ADD;
            10'b0100000_000: op_reg = SUB;
            10'b0000000_001: op_reg = SLL;
            10'b0000000_010: op_reg = SLT;
            10'b0000000_011: op_reg = SLTU;
            10'b0000000_100: op_reg = XOR;
            10'b0000000_101: op_reg = SRL;
            10'b0100000_101: op_reg = SRA;
            10'b0000000_110: op_reg = OR;
            10'b0000000_111: op_reg = AND;
            10'b0000001_000: op_reg = MUL;
            10'b0000001_001: op_reg = MULH;
            10'b0000001_010: op_reg = MULHSU;
            10'b0000001_011: op_reg = MULHU;
            10'b0000001_100: op_reg = DIV;
            10'b0000001_101: op_reg = DIVU;
            10'b0000001_110: op_reg = REM;
            10'b0000001_111: op_reg = REMU;
            default:         op_reg = INVALID;
        endcase
    end

    // Privileged ops need rs1 and rd zero; CSR ops are selected by funct3
    always_comb begin
        case (funct3)
            3'b000: begin
                case (instr_i[31:7])
                    25'h0000000: op_system = ECALL;
                    25'h0002000: op_system = EBREAK;
                    25'h0604000: op_system = MRET;
                    25'h020A000: op_system = WFI;
                    default:     op_system = INVALID;
                endcase
            end
            3'b001:  op_system = CSRRW;
            3'b010:  op_system = CSRRS;
            3'b011:  op_system = CSRRC;
            3'b101:  op_system = CSRRWI;
            3'b110:  op_system = CSRRSI;
            3'b111:  op_system = CSRRCI;
            default: op_system = INVALID;
        endcase
    end

    //////////////////////////////////////////////////
    // Opcode select
    //////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            `OPC_LUI:      operation_o = LUI;
            `OPC_AUIPC:    operation_o = ADD;
            `OPC_JAL:      operation_o = JAL;
            `OPC_JALR:     operation_o = (funct3 == 3'b000) ? JALR : INVALID;
            `OPC_BRANCH:   operation_o = op_branch;
            `OPC_LOAD:     operation_o = op_load;
            `OPC_STORE:    operation_o = op_store;
            `OPC_OP_IMM:   operation_o = op_imm;
            `OPC_OP:       operation_o = op_reg;
            // FENCE only, issued as a NOP
            `OPC_MISC_MEM: operation_o = (funct3 == 3'b000) ? NOP : INVALID;
            `OPC_SYSTEM:   operation_o = op_system;
            default:       operation_o = INVALID;
        endcase
    end

    assign illegal_o = (operation_o == INVALID);

endmodule

// File: logic/operand_builder.sv
// Combinational operand path; builds the immediate, forwards register data, selects operands
`include "decode_macros.svh"

module operand_builder
    import decode_pkg::*;
(
    input  word_t       instr_i,
    input  word_t       pc_i,
    input  word_t       rs1_data_i,
    input  word_t       rs2_data_i,
    input  word_t       result_i,
    input  word_t       writeback_i,
    input  reg_idx_t    rd_exec_i,
    input  reg_idx_t    rd_retire_i,
    input  logic        execute_we_i,
    input  logic        regbank_we_i,

    output word_t       first_operand_o,
    output word_t       second_operand_o,
    output word_t       third_operand_o,
    output logic        use_rs1_o,
    output logic        use_rs2_o
);

    reg_idx_t   rs1;
    reg_idx_t   rs2;
    format_e    format;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];

    //////////////////////////////////////////////////
    // Format and immediate
    //////////////////////////////////////////////////

    // OP, SYSTEM and MISC-MEM fall into R
    always_comb begin
        case (instr_i[6:0])
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: format = I_TYPE;
            `OPC_STORE:                        format = S_TYPE;
            `OPC_BRANCH:                       format = B_TYPE;
            `OPC_LUI, `OPC_AUIPC:              format = U_TYPE;
            `OPC_JAL:                          format = J_TYPE;
            default:                           format = R_TYPE;
        endcase
    end

    word_t imm;

    always_comb begin
        case (format)
            I_TYPE:  imm = {{21{instr_i[31]}}, instr_i[30:20]};
            S_TYPE:  imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
            B_TYPE:  imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            U_TYPE:  imm = {instr_i[31:12], 12'b0};
            J_TYPE:  imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Forwarding, execute before retire before bank
    //////////////////////////////////////////////////

    word_t rs1_fwd;
    word_t rs2_fwd;

    always_comb begin
        if (rs1 == rd_exec_i && execute_we_i) begin
            rs1_fwd = result_i;
        end else if (rs1 == rd_retire_i && regbank_we_i) begin
            rs1_fwd = writeback_i;
        end else begin
            rs1_fwd = rs1_data_i;
        end
    end

    always_comb begin
        if (rs2 == rd_exec_i && execute_we_i) begin
            rs2_fwd = result_i;
        end else if (rs2 == rd_retire_i && regbank_we_i) begin
            rs2_fwd = writeback_i;
        end else begin
            rs2_fwd = rs2_data_i;
        end
    end

    //////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////

    assign first_operand_o  = (format == U_TYPE || format == J_TYPE) ? pc_i : rs1_fwd;
    assign second_operand_o = (format == R_TYPE || format == B_TYPE) ? rs2_fwd : imm;
    assign third_operand_o  = (format == S_TYPE) ? rs2_fwd : imm;

    // Register use, feeds the load-use check
    assign use_rs1_o = (format != U_TYPE) && (format != J_TYPE);
    assign use_rs2_o = (format == R_TYPE) || (format == B_TYPE) || (format == S_TYPE);

endmodule
